/* Bender.yml */
package:
  name: tm1638_driver

sources:
  - common/tm1638_pkg.sv
  - common/display_pkg.sv
  - design/byte_fifo.sv
  - frame/frame_builder.sv
  - link/serial_link.sv
  - design/tm1638_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_tm1638.sv

/* common/display_pkg.sv */
// display value types, digit index type and the hex to seven-segment encoder
package display_pkg;

    localparam int num_digits = 8;

    typedef logic [4*num_digits-1:0] hex_value_t;
    typedef logic [num_digits-1:0] digit_mask_t;
    typedef logic [$clog2(num_digits)-1:0] digit_idx_t;
    typedef logic [3:0] nibble_t;

    // segments gfedcba
    typedef logic [6:0] seg_t;

    localparam seg_t seg_minus = 7'b100_0000;

    function automatic seg_t encode_hex(input nibble_t nib);
        seg_t seg;
        case (nib)
            4'h0: seg = 7'h3F;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5B;
            4'h3: seg = 7'h4F;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6D;
            4'h6: seg = 7'h7D;
            4'h7: seg = 7'h27;
            4'h8: seg = 7'h7F;
            4'h9: seg = 7'h6F;
            4'hA: seg = 7'h77;
            4'hB: seg = 7'h7C;
            4'hC: seg = 7'h39;
            4'hD: seg = 7'h5E;
            4'hE: seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return seg;
    endfunction

endpackage

/* common/tm1638_pkg.sv */
// link protocol commands, timing constants, counter types and the tagged link byte
package tm1638_pkg;

    localparam int clk_hz = 50_000_000;
    localparam int sclk_hz = 1_000_000;
    localparam int frame_rate = 250;

    // system clocks per serial clock half period
    localparam int sclk_half_div = clk_hz / (2 * sclk_hz);
    // system clocks per display frame
    localparam int frame_period = clk_hz / frame_rate;

    localparam int num_key_bytes = 4;
    localparam int fifo_depth = 4;

    // bit positions inside a key byte that carry a key
    localparam int key_sample_bit0 = 0;
    localparam int key_sample_bit1 = 4;

    typedef logic [7:0] byte_t;
    typedef logic [2:0] bit_idx_t;
    typedef logic [$clog2(sclk_half_div)-1:0] half_cnt_t;
    typedef logic [$clog2(frame_period)-1:0] frame_cnt_t;
    typedef logic [$clog2(num_key_bytes)-1:0] key_byte_idx_t;
    typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;
    typedef logic [$clog2(fifo_depth + 1)-1:0] fifo_cnt_t;

    // TM1638 commands
    localparam byte_t cmd_write_auto = 8'h40;
    localparam byte_t cmd_addr0 = 8'hC0;
    localparam byte_t cmd_display_on = 8'h8F;
    localparam byte_t cmd_read_keys = 8'h42;

    // one byte on the link plus its framing tags
    typedef struct packed {
        byte_t data;
        // strobe goes high after this byte
        logic  stb_end;
        // data line released, keys sampled
        logic  is_read;
    } link_byte_t;

endpackage

/* design/byte_fifo.sv */
// four entry FIFO of tagged link bytes with valid/ready on both sides
`timescale 1ns/1ps

module byte_fifo (
    input  logic                   CK_i,
    input  logic                   XARST_i,
    input  tm1638_pkg::link_byte_t wr_byte_i,
    input  logic                   wr_valid_i,
    output logic                   wr_ready_o,
    output tm1638_pkg::link_byte_t rd_byte_o,
    output logic                   rd_valid_o,
    input  logic                   rd_ready_i
);

    tm1638_pkg::link_byte_t mem [tm1638_pkg::fifo_depth];
    tm1638_pkg::fifo_ptr_t  wr_ptr;
    tm1638_pkg::fifo_ptr_t  rd_ptr;
    tm1638_pkg::fifo_cnt_t  count;
    logic                   do_wr;
    logic                   do_rd;

    function automatic tm1638_pkg::fifo_ptr_t next_ptr(input tm1638_pkg::fifo_ptr_t ptr);
        return (ptr == tm1638_pkg::fifo_depth - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_ready_o = (count != tm1638_pkg::fifo_depth);
    assign rd_valid_o = (count != 0);
    assign do_wr = wr_valid_i && wr_ready_o;
    assign do_rd = rd_valid_o && rd_ready_i;
    assign rd_byte_o = mem[rd_ptr];

    always_ff @(posedge CK_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_byte_i;
        end
    end

    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge CK_i) disable iff (!XARST_i)
        count <= tm1638_pkg::fifo_depth);

endmodule

/* design/tm1638_top.sv */
// TM1638 driver top with frame builder, byte FIFO and serial link
`timescale 1ns/1ps

module tm1638_top (
    input  logic                     CK_i,
    input  logic                     XARST_i,
    input  display_pkg::hex_value_t  bin_dat_i,
    input  display_pkg::digit_mask_t blank_digits_i,
    input  display_pkg::digit_mask_t dots_i,
    input  display_pkg::digit_mask_t leds_i,
    input  logic                     dio_i,
    output logic                     dio_o,
    output logic                     dio_oe_o,
    output logic                     sclk_o,
    output logic                     stb_o,
    output display_pkg::digit_mask_t keys_o
);

    tm1638_pkg::link_byte_t wr_byte;
    logic                   wr_valid;
    logic                   wr_ready;
    tm1638_pkg::link_byte_t rd_byte;
    logic                   rd_valid;
    logic                   rd_ready;

    frame_builder i_frame_builder (
        .CK_i           (CK_i),
        .XARST_i        (XARST_i),
        .bin_dat_i      (bin_dat_i),
        .blank_digits_i (blank_digits_i),
        .dots_i         (dots_i),
        .leds_i         (leds_i),
        .wr_byte_o      (wr_byte),
        .wr_valid_o     (wr_valid),
        .wr_ready_i     (wr_ready)
    );

    byte_fifo i_byte_fifo (
        .CK_i       (CK_i),
        .XARST_i    (XARST_i),
        .wr_byte_i  (wr_byte),
        .wr_valid_i (wr_valid),
        .wr_ready_o (wr_ready),
        .rd_byte_o  (rd_byte),
        .rd_valid_o (rd_valid),
        .rd_ready_i (rd_ready)
    );

    serial_link i_serial_link (
        .CK_i       (CK_i),
        .XARST_i    (XARST_i),
        .rd_byte_i  (rd_byte),
        .rd_valid_i (rd_valid),
        .rd_ready_o (rd_ready),
        .dio_i      (dio_i),
        .dio_o      (dio_o),
        .dio_oe_o   (dio_oe_o),
        .sclk_o     (sclk_o),
        .stb_o      (stb_o),
        .keys_o     (keys_o)
    );

endmodule

/* frame/frame_builder.sv */
// frame timer, display input snapshot and the tagged byte sequence of a frame
`timescale 1ns/1ps

module frame_builder (
    input  logic                     CK_i,
    input  logic                     XARST_i,
    input  display_pkg::hex_value_t  bin_dat_i,
    input  display_pkg::digit_mask_t blank_digits_i,
    input  display_pkg::digit_mask_t dots_i,
    input  display_pkg::digit_mask_t leds_i,
    output tm1638_pkg::link_byte_t   wr_byte_o,
    output logic                     wr_valid_o,
    input  logic                     wr_ready_i
);

    typedef enum logic [2:0] {
        st_idle,
        st_write_cmd,
        st_addr_cmd,
        st_digit,
        st_led,
        st_power_cmd,
        st_key_cmd,
        st_key_read
    } state_t;

    state_t                    state;
    tm1638_pkg::frame_cnt_t    frame_cnt;
    logic                      frame_tick;
    logic                      accept;
    display_pkg::digit_idx_t   digit_idx;
    tm1638_pkg::key_byte_idx_t read_cnt;
    display_pkg::hex_value_t   bin_q;
    display_pkg::digit_mask_t  blank_q;
    display_pkg::digit_mask_t  dots_q;
    display_pkg::digit_mask_t  leds_q;
    display_pkg::seg_t         digit_seg;

    assign frame_tick = (frame_cnt == tm1638_pkg::frame_period - 1);
    assign wr_valid_o = (state != st_idle);
    assign accept = wr_valid_o && wr_ready_i;

    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            frame_cnt <= '0;
        end else if (frame_tick) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // inputs are frozen for the whole frame
    always_ff @(posedge CK_i) begin
        if (frame_tick) begin
            bin_q <= bin_dat_i;
            blank_q <= blank_digits_i;
            dots_q <= dots_i;
            leds_q <= leds_i;
        end
    end

    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            state <= st_idle;
            digit_idx <= '0;
            read_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (frame_tick) begin
                        state <= st_write_cmd;
                    end
                end
                st_write_cmd: begin
                    if (accept) begin
                        state <= st_addr_cmd;
                    end
                end
                st_addr_cmd: begin
                    if (accept) begin
                        digit_idx <= '0;
                        state <= st_digit;
                    end
                end
                st_digit: begin
                    if (accept) begin
                        state <= st_led;
                    end
                end
                st_led: begin
                    if (accept) begin
                        if (digit_idx == display_pkg::num_digits - 1) begin
                            state <= st_power_cmd;
                        end else begin
                            digit_idx <= digit_idx + 1'b1;
                            state <= st_digit;
                        end
                    end
                end
                st_power_cmd: begin
                    if (accept) begin
                        state <= st_key_cmd;
                    end
                end
                st_key_cmd: begin
                    if (accept) begin
                        read_cnt <= '0;
                        state <= st_key_read;
                    end
                end
                st_key_read: begin
                    if (accept) begin
                        if (read_cnt == tm1638_pkg::num_key_bytes - 1) begin
                            state <= st_idle;
                        end else begin
                            read_cnt <= read_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // blanked digits show a minus
    assign digit_seg = blank_q[digit_idx] ? display_pkg::seg_minus
                     : display_pkg::encode_hex(bin_q[digit_idx * 4 +: 4]);

    always_comb begin
        wr_byte_o = '0;
        case (state)
            st_write_cmd: begin
                wr_byte_o.data = tm1638_pkg::cmd_write_auto;
                wr_byte_o.stb_end = 1'b1;
            end
            st_addr_cmd: wr_byte_o.data = tm1638_pkg::cmd_addr0;
            st_digit: wr_byte_o.data = {dots_q[digit_idx], digit_seg};
            st_led: begin
                wr_byte_o.data = {7'b0, leds_q[digit_idx]};
                wr_byte_o.stb_end = (digit_idx == display_pkg::num_digits - 1);
            end
            st_power_cmd: begin
                wr_byte_o.data = tm1638_pkg::cmd_display_on;
                wr_byte_o.stb_end = 1'b1;
            end
            st_key_cmd: wr_byte_o.data = tm1638_pkg::cmd_read_keys;
            st_key_read: begin
                wr_byte_o.is_read = 1'b1;
                wr_byte_o.stb_end = (read_cnt == tm1638_pkg::num_key_bytes - 1);
            end
            default: wr_byte_o = '0;
        endcase
    end

    a_byte_held: assert property (@(posedge CK_i) disable iff (!XARST_i)
        wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_byte_o));

    // a frame must drain before the next tick
    a_tick_when_idle: assert property (@(posedge CK_i) disable iff (!XARST_i)
        frame_tick |-> state == st_idle);

endmodule

/* link/serial_link.sv */
// serial clock divider, LSB first byte shifter, strobe and data direction, key capture
`timescale 1ns/1ps

module serial_link (
    input  logic                     CK_i,
    input  logic                     XARST_i,
    input  tm1638_pkg::link_byte_t   rd_byte_i,
    input  logic                     rd_valid_i,
    output logic                     rd_ready_o,
    input  logic                     dio_i,
    output logic                     dio_o,
    output logic                     dio_oe_o,
    output logic                     sclk_o,
    output logic                     stb_o,
    output display_pkg::digit_mask_t keys_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_shift,
        st_finish
    } state_t;

    state_t                    state;
    tm1638_pkg::half_cnt_t     half_cnt;
    logic                      half_tick;
    logic                      fall_en;
    logic                      rise_en;
    logic                      ready_q;
    logic                      accept;
    tm1638_pkg::byte_t         shift_q;
    tm1638_pkg::bit_idx_t      bit_cnt;
    tm1638_pkg::key_byte_idx_t key_idx;
    display_pkg::digit_mask_t  key_stage;
    logic                      cur_stb_end;
    logic                      cur_is_read;

    assign rd_ready_o = ready_q;
    assign accept = ready_q && rd_valid_i;

    // half period divider, restarted for every byte
    assign half_tick = (half_cnt == tm1638_pkg::sclk_half_div - 1);
    assign fall_en = half_tick && sclk_o;
    assign rise_en = half_tick && !sclk_o;

    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            half_cnt <= '0;
        end else if (accept || half_tick) begin
            half_cnt <= '0;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            state <= st_idle;
            ready_q <= 1'b0;
            sclk_o <= 1'b1;
            stb_o <= 1'b1;
            dio_o <= 1'b0;
            dio_oe_o <= 1'b0;
            bit_cnt <= '0;
            key_idx <= '0;
            cur_stb_end <= 1'b0;
            cur_is_read <= 1'b0;
            keys_o <= '0;
        end else begin
            case (state)
                st_idle: begin
                    ready_q <= 1'b1;
                    if (accept) begin
                        ready_q <= 1'b0;
                        cur_stb_end <= rd_byte_i.stb_end;
                        cur_is_read <= rd_byte_i.is_read;
                        // strobe setup lasts the start half period
                        stb_o <= 1'b0;
                        dio_oe_o <= !rd_byte_i.is_read;
                        bit_cnt <= '0;
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (fall_en) begin
                        sclk_o <= 1'b0;
                        dio_o <= shift_q[0];
                        state <= st_shift;
                    end
                end
                st_shift: begin
                    if (fall_en) begin
                        sclk_o <= 1'b0;
                        dio_o <= shift_q[0];
                    end else if (rise_en) begin
                        sclk_o <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == '1) begin
                            state <= st_finish;
                        end
                    end
                end
                st_finish: begin
                    dio_oe_o <= 1'b0;
                    dio_o <= 1'b0;
                    if (cur_stb_end) begin
                        stb_o <= 1'b1;
                    end
                    if (cur_is_read) begin
                        if (cur_stb_end) begin
                            keys_o <= key_stage;
                            key_idx <= '0;
                        end else begin
                            key_idx <= key_idx + 1'b1;
                        end
                    end
                    ready_q <= 1'b1;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // board drives dio after the fall, so it is settled by the rise
    always_ff @(posedge CK_i) begin
        if (accept) begin
            shift_q <= rd_byte_i.data;
        end else if (state == st_shift && rise_en) begin
            shift_q <= {1'b0, shift_q[7:1]};
            if (cur_is_read && bit_cnt == tm1638_pkg::key_sample_bit0) begin
                key_stage[display_pkg::num_digits - 1 - 2 * key_idx] <= dio_i;
            end
            if (cur_is_read && bit_cnt == tm1638_pkg::key_sample_bit1) begin
                key_stage[display_pkg::num_digits - 2 - 2 * key_idx] <= dio_i;
            end
        end
    end

    a_idle_clock_high: assert property (@(posedge CK_i) disable iff (!XARST_i)
        (state == st_idle) && stb_o |-> sclk_o);

    a_read_released: assert property (@(posedge CK_i) disable iff (!XARST_i)
        (state != st_idle) && cur_is_read |-> !dio_oe_o);

endmodule

/* project.f */
common/tm1638_pkg.sv
common/display_pkg.sv
design/byte_fifo.sv
frame/frame_builder.sv
link/serial_link.sv
design/tm1638_top.sv
tests/tb_clock_gen.sv
tests/tb_tm1638.sv

/* tests/tb_clock_gen.sv */
// testbench clock and active low reset generator
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real period_ns = 20.0,
    parameter int  reset_cycles = 10
) (
    output logic CK_o,
    output logic XARST_o
);

    initial begin
        CK_o = 1'b0;
        forever #(period_ns / 2.0) CK_o = ~CK_o;
    end

    // release a little after the edge, like the other inputs
    initial begin
        XARST_o = 1'b0;
        repeat (reset_cycles) @(posedge CK_o);
        #1 XARST_o = 1'b1;
    end

endmodule

/* tests/tb_tm1638.sv */
// testbench top with stimulus table, TM1638 board model, frame checks and watchdog
`timescale 1ns/1ps

module tb_tm1638;

    localparam int num_rows = 8;
    localparam int frame_bytes = 24;
    localparam int first_read_byte = 20;
    localparam longint clk_period_ns = 20;
    localparam longint timeout_ns =
        (num_rows + 2) * longint'(tm1638_pkg::frame_period) * clk_period_ns;

    // hex font, nibble F in the top bits down to nibble 0
    localparam logic [16*7-1:0] font = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
                                        7'h27, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

    typedef struct packed {
        display_pkg::hex_value_t  bin;
        display_pkg::digit_mask_t blank;
        display_pkg::digit_mask_t dots;
        display_pkg::digit_mask_t leds;
        display_pkg::digit_mask_t keys;
    } row_t;

    logic                     ck;
    logic                     xarst;
    display_pkg::hex_value_t  bin_dat;
    display_pkg::digit_mask_t blank_digits;
    display_pkg::digit_mask_t dots;
    display_pkg::digit_mask_t leds;
    logic                     dio_in;
    logic                     dio_out;
    logic                     dio_oe;
    logic                     sclk;
    logic                     stb;
    display_pkg::digit_mask_t keys;

    row_t                     rows [num_rows];
    logic [15:0]              lfsr_q;
    display_pkg::digit_mask_t key_pattern;

    // board model state
    int                       bit_pos;
    logic [7:0]               shift_in;
    logic                     byte_read;
    int                       group_bytes;
    int                       group_cnt;
    int                       read_idx;
    logic [7:0]               frame_data [$];
    logic                     frame_read [$];
    int                       group_size [$];

    tb_clock_gen #(.period_ns(20.0), .reset_cycles(10)) i_clock_gen (
        .CK_o    (ck),
        .XARST_o (xarst)
    );

    tm1638_top i_dut (
        .CK_i           (ck),
        .XARST_i        (xarst),
        .bin_dat_i      (bin_dat),
        .blank_digits_i (blank_digits),
        .dots_i         (dots),
        .leds_i         (leds),
        .dio_i          (dio_in),
        .dio_o          (dio_out),
        .dio_oe_o       (dio_oe),
        .sclk_o         (sclk),
        .stb_o          (stb),
        .keys_o         (keys)
    );

    task automatic fail_run(input string msg);
        $display("** Error: %s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error: %s: expected %0h, actual %0h", name, expected, actual);
            fail_run("value mismatch");
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    task automatic lfsr_word(output display_pkg::hex_value_t word);
        for (int b = 0; b < 32; b++) begin
            word[b] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic fill_table();
        display_pkg::hex_value_t rand_bin;
        // columns: bin value, blanking mask, dots, leds, key pattern
        rows[0] = {32'h7654_3210, 8'h00, 8'h00, 8'h00, 8'h00};
        rows[1] = {32'hFEDC_BA98, 8'h00, 8'hFF, 8'hFF, 8'hFF};
        rows[2] = {32'h0123_ABCD, 8'h81, 8'h55, 8'hAA, 8'hA5};
        rows[3] = {32'hDEAD_BEEF, 8'hFF, 8'h0F, 8'h3C, 8'h5A};
        rows[4] = {32'h0000_0000, 8'h24, 8'h80, 8'h01, 8'h81};
        rows[5] = {32'h89AB_CDEF, 8'h00, 8'h01, 8'h80, 8'h3C};
        lfsr_word(rand_bin);
        rows[6] = {rand_bin, 8'h10, 8'h22, 8'h99, 8'h96};
        lfsr_word(rand_bin);
        rows[7] = {rand_bin, 8'h00, 8'hC3, 8'h66, 8'h69};
    endtask

    // read byte j carries key 7-2j at bit 0 and key 6-2j at bit 4
    function automatic logic key_bit(input display_pkg::digit_mask_t pattern,
                                     input int idx, input int pos);
        if (idx > 3) return 1'b0;
        if (pos == 0) return pattern[7 - 2 * idx];
        if (pos == 4) return pattern[6 - 2 * idx];
        return 1'b0;
    endfunction

    function automatic logic [7:0] expected_byte(input row_t row, input int pos);
        int k;
        int nib;
        logic [6:0] seg;
        case (pos)
            0: return 8'h40;
            1: return 8'hC0;
            18: return 8'h8F;
            19: return 8'h42;
            default: k = (pos - 2) / 2;
        endcase
        if (pos % 2 == 1) return {7'b0, row.leds[k]};
        nib = row.bin[4 * k +: 4];
        seg = row.blank[k] ? 7'h40 : font[nib * 7 +: 7];
        return {row.dots[k], seg};
    endfunction

    task automatic apply_row(input row_t row);
        frame_data.delete();
        frame_read.delete();
        group_size.delete();
        group_cnt = 0;
        group_bytes = 0;
        read_idx = 0;
        bin_dat = row.bin;
        blank_digits = row.blank;
        dots = row.dots;
        leds = row.leds;
        key_pattern = row.keys;
    endtask

    task automatic check_frame(input int r);
        string tag;
        int exp_len;
        check_equal($sformatf("row %0d strobe groups", r), 4, group_size.size());
        for (int g = 0; g < 4; g++) begin
            exp_len = (g == 1) ? 17 : (g == 3) ? 5 : 1;
            check_equal($sformatf("row %0d group %0d size", r, g), exp_len, group_size[g]);
        end
        check_equal($sformatf("row %0d byte count", r), frame_bytes, frame_data.size());
        for (int i = 0; i < frame_bytes; i++) begin
            tag = $sformatf("row %0d byte %0d", r, i);
            check_equal({tag, " read"}, i >= first_read_byte, frame_read[i]);
            if (i < first_read_byte) begin
                check_equal({tag, " data"}, expected_byte(rows[r], i), frame_data[i]);
            end
        end
        check_equal($sformatf("row %0d keys", r), rows[r].keys, keys);
    endtask

    // board samples on the rising serial clock while strobed
    always @(posedge sclk) begin
        if (xarst && !stb) begin
            if (bit_pos == 0) begin
                byte_read = !dio_oe;
            end else begin
                assert (byte_read == !dio_oe) else
                    fail_run("data direction changed in the middle of a byte");
            end
            shift_in[bit_pos] = dio_out;
            if (bit_pos == 7) begin
                frame_data.push_back(shift_in);
                frame_read.push_back(byte_read);
                group_bytes++;
                if (byte_read) begin
                    read_idx++;
                end
                bit_pos = 0;
            end else begin
                bit_pos++;
            end
        end
    end

    // key bits go out after the falling edge
    always @(negedge sclk) begin
        #1;
        if (!stb && !dio_oe) begin
            dio_in = key_bit(key_pattern, read_idx, bit_pos);
        end else begin
            dio_in = 1'b0;
        end
    end

    always @(posedge stb) begin
        if (xarst) begin
            group_size.push_back(group_bytes);
            group_bytes = 0;
            group_cnt++;
        end
    end

    initial begin
        #(timeout_ns);
        fail_run("timeout, the frames did not complete in time");
    end

    initial begin
        bin_dat = '0;
        blank_digits = '0;
        dots = '0;
        leds = '0;
        dio_in = 1'b0;
        key_pattern = '0;
        bit_pos = 0;
        shift_in = '0;
        byte_read = 1'b0;
        group_bytes = 0;
        group_cnt = 0;
        read_idx = 0;
        lfsr_q = 16'd81;
        fill_table();
        wait (xarst === 1'b1);
        @(posedge ck);
        #1;
        check_equal("reset stb", 1, stb);
        check_equal("reset sclk", 1, sclk);
        check_equal("reset dio_oe", 0, dio_oe);
        check_equal("reset keys", 0, keys);
        for (int r = 0; r < num_rows; r++) begin
            apply_row(rows[r]);
            wait (group_cnt == 4);
            @(posedge ck);
            #1;
            check_frame(r);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
